/* Makefile */
TOP = mipsCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

    localparam logic [31:0] resetPc = 32'h0000_0100;
    localparam int bodyLen = 120;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic        fetchStall;
    logic [31:0] instr;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memEn;
    logic        memWrite;
    logic [31:0] memReadData;

    logic [31:0] imem [512];
    logic [31:0] dmem [4096];
    logic [31:0] modelMem [4096];
    logic [31:0] modelReg [32];
    logic [31:0] expAddr [256];
    logic [31:0] expData [256];
    bit          noTarget [512]; // words a branch must not land on
    int          nStores;
    int          storeIdx;
    int          storeErrors, memErrors, otherErrors;
    logic [31:0] rngState;
    logic [31:0] haltPc;
    logic [31:0] nextInstr;
    logic        pendWrite;
    logic [31:0] pendAddr, pendData;

    mipsCore #(
        .resetPc(resetPc)
    ) mipsCore_i (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .fetchStall  (fetchStall),
        .instr       (instr),
        .memAddr     (memAddr),
        .memWriteData(memWriteData),
        .memEn       (memEn),
        .memWrite    (memWrite),
        .memReadData (memReadData)
    );

    assign memReadData = dmem[memAddr[13:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift(rngState);
        return int'(rngState % 32'(n));
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {opSpecial, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // half the time rs reuses the last destination, to force forwarding
    function automatic logic [31:0] randAlu(input logic [4:0] near, output logic [4:0] dst);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        int          pick;
        dst  = 5'(1 + randBelow(15));
        rs   = (randBelow(2) == 0) ? near : 5'(randBelow(16));
        rt   = 5'(randBelow(16));
        imm  = 16'(randBelow(65536));
        pick = randBelow(12);
        case (pick)
            0: return rType(functAddu, rs, rt, dst, 5'd0);
            1: return rType(functSubu, rs, rt, dst, 5'd0);
            2: return rType(functAnd, rs, rt, dst, 5'd0);
            3: return rType(functOr, rs, rt, dst, 5'd0);
            4: return rType(functXor, rs, rt, dst, 5'd0);
            5: return rType(functSlt, rs, rt, dst, 5'd0);
            6: return rType(functSll, 5'd0, rs, dst, imm[4:0]);
            7: return rType(functSrl, 5'd0, rs, dst, imm[4:0]);
            8: return iType(opAddiu, rs, dst, imm);
            9: return iType(opAndi, rs, dst, imm);
            10: return iType(opOri, rs, dst, imm);
            default: return iType(opLui, 5'd0, dst, imm);
        endcase
    endfunction

    task automatic buildProgram();
        int          n;
        int          base;
        int          bodyEnd;
        int          kind;
        int          t;
        int          ctl [$];
        logic [4:0]  last;
        logic [4:0]  r;
        logic [4:0]  rs;
        logic [15:0] addr;
        logic [31:0] w;
        base = int'(resetPc[10:2]);
        n    = base;
        last = 5'd1;
        for (int i = 0; i < 512; i++) begin
            imem[i]     = 32'd0;
            noTarget[i] = 1'b0;
        end
        for (int i = 1; i < 32; i++) begin
            imem[n] = iType((i % 2 == 1) ? opOri : opAddiu, 5'd0, 5'(i), 16'(randBelow(65536)));
            n++;
        end
        bodyEnd = n + bodyLen;
        while (n < bodyEnd) begin
            kind = randBelow(20);
            if (kind >= 18 && bodyEnd - n >= 3) begin
                r = 5'(1 + randBelow(15)); // ori loads the jr target below
                imem[n]         = iType(opOri, 5'd0, r, 16'd0);
                imem[n + 1]     = rType(functJr, r, 5'd0, 5'd0, 5'd0);
                noTarget[n + 1] = 1'b1;
                ctl.push_back(n + 1);
                imem[n + 2] = randAlu(last, last);
                n += 3;
            end else if (kind >= 14 && bodyEnd - n >= 2) begin
                rs = (randBelow(2) == 0) ? last : 5'(randBelow(16));
                r  = 5'(randBelow(16));
                case (kind)
                    14: w = iType(opBeq, rs, r, 16'd0);
                    15: w = iType(opBne, rs, r, 16'd0);
                    16: w = {opJ, 26'd0};
                    default: w = {opJal, 26'd0};
                endcase
                imem[n] = w;
                ctl.push_back(n);
                imem[n + 1] = randAlu(last, last); // delay slot
                n += 2;
            end else if (kind >= 10) begin
                addr = 16'h1000 + 16'(4 * randBelow(64));
                if (kind >= 12) begin
                    last    = 5'(1 + randBelow(15));
                    imem[n] = iType(opLw, 5'd0, last, addr);
                end else begin
                    r       = (randBelow(2) == 0) ? last : 5'(randBelow(16));
                    imem[n] = iType(opSw, 5'd0, r, addr);
                end
                n++;
            end else begin
                imem[n] = randAlu(last, last);
                n++;
            end
        end
        // dump every register, then spin
        for (int i = 1; i < 32; i++) begin
            imem[n] = iType(opSw, 5'd0, 5'(i), 16'(32'h2000 + 32'(4 * i)));
            n++;
        end
        haltPc      = resetPc + 32'(4 * (n - base));
        imem[n]     = {opJ, haltPc[27:2]};
        imem[n + 1] = 32'd0;
        foreach (ctl[k]) begin
            t = ctl[k] + 2 + randBelow(6);
            if (t > bodyEnd) begin
                t = bodyEnd;
            end
            while (noTarget[t]) begin
                t++;
            end
            w = resetPc + 32'(4 * (t - base));
            case (imem[ctl[k]][31:26])
                opBeq, opBne: imem[ctl[k]][15:0] = 16'(t - ctl[k] - 1);
                opJ, opJal:   imem[ctl[k]][25:0] = w[27:2];
                default:      imem[ctl[k] - 1][15:0] = w[15:0]; // jr
            endcase
        end
    endtask

    // instruction-set model, one instruction per step with a delay slot
    task automatic runModel();
        logic [31:0] mpc, mnpc, nn, seq, ins, a, b, imm, res, addr;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            modelReg[i] = 32'd0;
        end
        mpc     = resetPc;
        mnpc    = resetPc + 32'd4;
        nStores = 0;
        steps   = 0;
        while (mpc != haltPc && steps < 4000) begin
            ins  = imem[mpc[10:2]];
            a    = modelReg[ins[25:21]];
            b    = modelReg[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            seq  = mpc + 32'd4;
            nn   = mnpc + 32'd4;
            wr   = 1'b1;
            dst  = ins[20:16];
            res  = 32'd0;
            case (ins[31:26])
                opSpecial: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        functAddu: res = a + b;
                        functSubu: res = a - b;
                        functAnd:  res = a & b;
                        functOr:   res = a | b;
                        functXor:  res = a ^ b;
                        functSlt:  res = {31'd0, $signed(a) < $signed(b)};
                        functSll:  res = b << ins[10:6];
                        functSrl:  res = b >> ins[10:6];
                        functJr: begin
                            wr = 1'b0;
                            nn = a;
                        end
                        default:   wr = 1'b0;
                    endcase
                end
                opAddiu: res = addr;
                opAndi:  res = a & {16'd0, ins[15:0]};
                opOri:   res = a | {16'd0, ins[15:0]};
                opLui:   res = {ins[15:0], 16'd0};
                opLw:    res = modelMem[addr[13:2]];
                opSw: begin
                    wr = 1'b0;
                    modelMem[addr[13:2]] = b;
                    expAddr[nStores]     = addr;
                    expData[nStores]     = b;
                    nStores++;
                end
                opBeq: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nn = seq + (imm << 2);
                    end
                end
                opBne: begin
                    wr = 1'b0;
                    if (a != b) begin
                        nn = seq + (imm << 2);
                    end
                end
                opJ: begin
                    wr = 1'b0;
                    nn = {seq[31:28], ins[25:0], 2'b00};
                end
                opJal: begin
                    dst = 5'd31;
                    res = mpc + 32'd8; // past the delay slot
                    nn  = {seq[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                modelReg[dst] = res;
            end
            mpc  = mnpc;
            mnpc = nn;
            steps++;
        end
        assert (mpc == haltPc) else begin
            otherErrors++;
            $display("the model ran %0d steps without reaching the halt loop", steps);
        end
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        assert (storeIdx < nStores) else begin
            otherErrors++;
            $display("%0t: unexpected store of %h to %h after the last expected one",
                     $time, data, addr);
        end
        if (storeIdx < nStores) begin
            assert (addr === expAddr[storeIdx] && data === expData[storeIdx]) else begin
                storeErrors++;
                $display("CHECK FAILED at %0t: store %0d expected [%h] = %h, got [%h] = %h",
                         $time, storeIdx, expAddr[storeIdx], expData[storeIdx], addr, data);
            end
        end
        storeIdx++;
    endtask

    // ports are stable mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            nextInstr = 32'd0;
        end else if (!fetchStall) begin
            nextInstr = imem[pc[10:2]];
        end
        if (!reset && memEn && memWrite) begin
            pendWrite = 1'b1;
            pendAddr  = memAddr;
            pendData  = memWriteData;
            checkStore(memAddr, memWriteData);
        end
        // every load of the program reads the 64-word region at 0x1000
        if (!reset && memEn && !memWrite) begin
            assert (memAddr[31:8] == 24'h10 && memAddr[1:0] == 2'b00) else begin
                otherErrors++;
                $display("CHECK FAILED at %0t: load from %h outside the data region",
                         $time, memAddr);
            end
        end
    end

    // registered fetch and data write land just after the edge
    always @(posedge clk) begin
        #1;
        instr = nextInstr;
        if (pendWrite) begin
            dmem[pendAddr[13:2]] = pendData;
            pendWrite = 1'b0;
        end
    end

    initial begin
        int cycles;
        reset       = 1'b1;
        instr       = 32'd0;
        nextInstr   = 32'd0;
        pendWrite   = 1'b0;
        pendAddr    = 32'd0;
        pendData    = 32'd0;
        storeIdx    = 0;
        storeErrors = 0;
        memErrors   = 0;
        otherErrors = 0;
        rngState    = 32'h8398;
        for (int i = 0; i < 4096; i++) begin
            dmem[i]     = fillWord(32'(i * 4));
            modelMem[i] = dmem[i];
        end
        buildProgram();
        runModel();

        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            #1;
            assert (memEn === 1'b0 && memWrite === 1'b0 && pc === resetPc) else begin
                otherErrors++;
                $display("CHECK FAILED at %0t: in reset pc %h memEn %b memWrite %b",
                         $time, pc, memEn, memWrite);
            end
        end
        reset = 1'b0;
        @(negedge clk);
        assert (pc === resetPc && memEn === 1'b0 && memWrite === 1'b0) else begin
            otherErrors++;
            $display("CHECK FAILED at %0t: first pc after reset %h, expected %h",
                     $time, pc, resetPc);
        end

        cycles = 0;
        while (storeIdx < nStores && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (storeIdx < nStores) begin
            otherErrors++;
            $display("timed out after 5000 cycles with %0d of %0d stores seen",
                     storeIdx, nStores);
        end else begin
            cycles = 0;
            while (cycles < 20) begin // core spins and no store may appear
                @(posedge clk);
                cycles++;
            end
            for (int i = 0; i < 4096; i++) begin
                assert (dmem[i] === modelMem[i]) else begin
                    memErrors++;
                    $display("CHECK FAILED at %0t: word at %h expected %h, got %h",
                             $time, 32'(i * 4), modelMem[i], dmem[i]);
                end
            end
        end

        $display("errors: %0d store, %0d memory, %0d other (%0d stores expected)",
                 storeErrors, memErrors, otherErrors, nStores);
        if (storeErrors + memErrors + otherErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/mipsPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/controller.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/mipsCore.sv
dv/mipsCoreTb.sv

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  aluOp_t      aluOp,
    output logic [31:0] result
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'd0, lessThan};
            aluSll:  result = b << shamt; // shifts act on rt
            aluSrl:  result = b >> shamt;
            aluLui:  result = {b[15:0], 16'd0};
            default: result = 32'd0;
        endcase
    end

endmodule

/* verilog/controller.sv */
`timescale 1ns/1ps

module controller import mipsPkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output logic       regWrite,
    output regDst_t    regDst,
    output logic       aluSrcImm,
    output aluOp_t     aluOp,
    output logic       memToReg,
    output logic       memEn,
    output logic       memWrite,
    output logic       branch,
    output logic       branchNe,
    output logic       jump,
    output logic       jumpReg,
    output logic       link
);

    always_comb begin
        regWrite  = 1'b0;
        regDst    = dstRt;
        aluSrcImm = 1'b0;
        aluOp     = aluAdd;
        memToReg  = 1'b0;
        memEn     = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        link      = 1'b0;
        case (opcode)
            opSpecial: begin
                regDst   = dstRd;
                regWrite = 1'b1;
                case (funct)
                    functAddu: aluOp = aluAdd;
                    functSubu: aluOp = aluSub;
                    functAnd:  aluOp = aluAnd;
                    functOr:   aluOp = aluOr;
                    functXor:  aluOp = aluXor;
                    functSlt:  aluOp = aluSlt;
                    functSll:  aluOp = aluSll;
                    functSrl:  aluOp = aluSrl;
                    functJr: begin
                        regWrite = 1'b0;
                        jumpReg  = 1'b1;
                    end
                    default: regWrite = 1'b0; // unknown funct acts as a nop
                endcase
            end
            opAddiu: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opAndi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluAnd;
            end
            opOri: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluOr;
            end
            opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluLui;
            end
            opLw: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
                memEn     = 1'b1;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memEn     = 1'b1;
                memWrite  = 1'b1;
            end
            opBeq: branch = 1'b1;
            opBne: begin
                branch   = 1'b1;
                branchNe = 1'b1;
            end
            opJ: jump = 1'b1;
            opJal: begin
                jump     = 1'b1;
                link     = 1'b1;
                regWrite = 1'b1;
                regDst   = dstRa;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ps

module datapath import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic        regWriteD,
    input  regDst_t     regDstD,
    input  logic        aluSrcImmD,
    input  aluOp_t      aluOpD,
    input  logic        memToRegD,
    input  logic        memEnD,
    input  logic        memWriteD,
    input  logic        branchD,
    input  logic        branchNeD,
    input  logic        jumpD,
    input  logic        jumpRegD,
    input  logic        linkD,
    input  forwardSel_t forwardAE,
    input  forwardSel_t forwardBE,
    input  logic        forwardAD,
    input  logic        forwardBD,
    input  logic        stallF,
    input  logic        stallD,
    input  logic        flushE,
    output logic [4:0]  rsD,
    output logic [4:0]  rtD,
    output logic [4:0]  rsE,
    output logic [4:0]  rtE,
    output logic [4:0]  writeRegE,
    output logic [4:0]  writeRegM,
    output logic [4:0]  writeRegW,
    output logic        regWriteE,
    output logic        regWriteM,
    output logic        regWriteW,
    output logic        memToRegE,
    output logic        memToRegM,
    output logic [31:0] pc,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memEn,
    output logic        memWrite,
    input  logic [31:0] memReadData
);

    logic [31:0] pcNext, pcPlus4F;
    logic [31:0] pcPlus4D, pcPlus8D, pcBranchD, pcJumpD;
    logic [31:0] immD, readData1D, readData2D, cmpAD, cmpBD;
    logic [4:0]  rdD, shamtD;
    logic        zeroExtD, branchTakenD;
    logic        aluSrcImmE, memEnE, memWriteE, linkE;
    regDst_t     regDstE;
    aluOp_t      aluOpE;
    logic [31:0] readData1E, readData2E, immE, pcPlus8E;
    logic [31:0] srcAE, srcBE, writeDataE, aluResultE, resultE;
    logic [4:0]  rdE, shamtE;
    logic        memEnM, memWriteM;
    logic [31:0] aluOutM, writeDataM;
    logic        memToRegW;
    logic [31:0] aluOutW, readDataW, resultW;

    function automatic logic [31:0] fwdMux(
        input forwardSel_t sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign pcPlus4F = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end

    // instr is already the decode instruction, only its pc+4 needs a register
    always_ff @(posedge clk) begin
        if (reset) begin
            pcPlus4D <= 32'd0;
        end else if (!stallD) begin
            pcPlus4D <= pcPlus4F;
        end
    end

    assign rsD    = instr[25:21];
    assign rtD    = instr[20:16];
    assign rdD    = instr[15:11];
    assign shamtD = instr[10:6];

    assign zeroExtD = (aluOpD == aluAnd) || (aluOpD == aluOr); // andi, ori
    assign immD     = zeroExtD ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    regFile regFile_i (
        .clk        (clk),
        .writeEnable(regWriteW),
        .readAddr1  (rsD),
        .readAddr2  (rtD),
        .writeAddr  (writeRegW),
        .writeData  (resultW),
        .readData1  (readData1D),
        .readData2  (readData2D)
    );

    assign cmpAD = forwardAD ? aluOutM : readData1D;
    assign cmpBD = forwardBD ? aluOutM : readData2D;
    assign branchTakenD = branchD && ((cmpAD == cmpBD) != branchNeD);

    assign pcBranchD = pcPlus4D + {immD[29:0], 2'b00};
    assign pcJumpD   = {pcPlus4D[31:28], instr[25:0], 2'b00};
    assign pcPlus8D  = pcPlus4D + 32'd4; // return address past the delay slot

    assign pcNext = jumpRegD     ? cmpAD :
                    jumpD        ? pcJumpD :
                    branchTakenD ? pcBranchD : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset || flushE) begin
            regWriteE  <= 1'b0;
            regDstE    <= dstRt;
            aluSrcImmE <= 1'b0;
            aluOpE     <= aluAdd;
            memToRegE  <= 1'b0;
            memEnE     <= 1'b0;
            memWriteE  <= 1'b0;
            linkE      <= 1'b0;
        end else begin
            regWriteE  <= regWriteD;
            regDstE    <= regDstD;
            aluSrcImmE <= aluSrcImmD;
            aluOpE     <= aluOpD;
            memToRegE  <= memToRegD;
            memEnE     <= memEnD;
            memWriteE  <= memWriteD;
            linkE      <= linkD;
        end
        readData1E <= readData1D;
        readData2E <= readData2D;
        rsE        <= rsD;
        rtE        <= rtD;
        rdE        <= rdD;
        shamtE     <= shamtD;
        immE       <= immD;
        pcPlus8E   <= pcPlus8D;
    end

    assign srcAE      = fwdMux(forwardAE, readData1E, aluOutM, resultW);
    assign writeDataE = fwdMux(forwardBE, readData2E, aluOutM, resultW);
    assign srcBE      = aluSrcImmE ? immE : writeDataE;

    alu alu_i (
        .a     (srcAE),
        .b     (srcBE),
        .shamt (shamtE),
        .aluOp (aluOpE),
        .result(aluResultE)
    );

    assign resultE = linkE ? pcPlus8E : aluResultE;

    always_comb begin
        case (regDstE)
            dstRd:   writeRegE = rdE;
            dstRa:   writeRegE = 5'd31;
            default: writeRegE = rtE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memEnM    <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
            memEnM    <= memEnE;
            memWriteM <= memWriteE;
        end
        aluOutM    <= resultE;
        writeDataM <= writeDataE;
        writeRegM  <= writeRegE;
    end

    assign memAddr      = aluOutM;
    assign memWriteData = writeDataM;
    assign memEn        = memEnM;
    assign memWrite     = memWriteM;

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
        end
        aluOutW   <= aluOutM;
        readDataW <= memReadData; // data read is combinational
        writeRegW <= writeRegM;
    end

    assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  logic [4:0]  rsD,
    input  logic [4:0]  rtD,
    input  logic [4:0]  rsE,
    input  logic [4:0]  rtE,
    input  logic [4:0]  writeRegE,
    input  logic [4:0]  writeRegM,
    input  logic [4:0]  writeRegW,
    input  logic        regWriteE,
    input  logic        regWriteM,
    input  logic        regWriteW,
    input  logic        memToRegE,
    input  logic        memToRegM,
    input  logic        branch,
    input  logic        jumpReg,
    output forwardSel_t forwardAE,
    output forwardSel_t forwardBE,
    output logic        forwardAD,
    output logic        forwardBD,
    output logic        stallF,
    output logic        stallD,
    output logic        flushE
);

    logic loadUseStall;
    logic branchStall;
    logic rsBusy;
    logic rtBusy;

    function automatic forwardSel_t execSel(
        input logic [4:0] src,
        input logic [4:0] regM,
        input logic       writeM,
        input logic [4:0] regW,
        input logic       writeW
    );
        if (src != 5'd0 && src == regM && writeM) begin
            return fwdMem; // newest value wins
        end else if (src != 5'd0 && src == regW && writeW) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign forwardAE = execSel(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
    assign forwardBE = execSel(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

    // writeback needs no path here, the regfile writes on the falling edge
    assign forwardAD = rsD != 5'd0 && rsD == writeRegM && regWriteM;
    assign forwardBD = rtD != 5'd0 && rtD == writeRegM && regWriteM;

    assign loadUseStall = memToRegE && rtE != 5'd0 && (rtE == rsD || rtE == rtD);

    // operand still in execute, or a load in memory whose data is not back yet
    assign rsBusy = rsD != 5'd0 && ((regWriteE && writeRegE == rsD) ||
                                    (memToRegM && writeRegM == rsD));
    assign rtBusy = rtD != 5'd0 && ((regWriteE && writeRegE == rtD) ||
                                    (memToRegM && writeRegM == rtD));
    assign branchStall = (branch && (rsBusy || rtBusy)) || (jumpReg && rsBusy);

    assign stallF = loadUseStall || branchStall;
    assign stallD = loadUseStall || branchStall;
    assign flushE = loadUseStall || branchStall;

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    output logic        fetchStall,
    input  logic [31:0] instr,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memEn,
    output logic        memWrite,
    input  logic [31:0] memReadData
);

    logic        regWrite, aluSrcImm, memToReg, memEnD, memWriteD;
    logic        branch, branchNe, jump, jumpReg, link;
    regDst_t     regDst;
    aluOp_t      aluOp;
    forwardSel_t forwardAE, forwardBE;
    logic        forwardAD, forwardBD, stallF, stallD, flushE;
    logic [4:0]  rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW;
    logic        regWriteE, regWriteM, regWriteW, memToRegE, memToRegM;

    assign fetchStall = stallD; // instruction memory holds with decode

    controller controller_i (
        .opcode   (instr[31:26]),
        .funct    (instr[5:0]),
        .regWrite (regWrite),
        .regDst   (regDst),
        .aluSrcImm(aluSrcImm),
        .aluOp    (aluOp),
        .memToReg (memToReg),
        .memEn    (memEnD),
        .memWrite (memWriteD),
        .branch   (branch),
        .branchNe (branchNe),
        .jump     (jump),
        .jumpReg  (jumpReg),
        .link     (link)
    );

    hazardUnit hazardUnit_i (
        .rsD      (rsD),
        .rtD      (rtD),
        .rsE      (rsE),
        .rtE      (rtE),
        .writeRegE(writeRegE),
        .writeRegM(writeRegM),
        .writeRegW(writeRegW),
        .regWriteE(regWriteE),
        .regWriteM(regWriteM),
        .regWriteW(regWriteW),
        .memToRegE(memToRegE),
        .memToRegM(memToRegM),
        .branch   (branch),
        .jumpReg  (jumpReg),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE),
        .forwardAD(forwardAD),
        .forwardBD(forwardBD),
        .stallF   (stallF),
        .stallD   (stallD),
        .flushE   (flushE)
    );

    datapath #(
        .resetPc(resetPc)
    ) datapath_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .regWriteD   (regWrite),
        .regDstD     (regDst),
        .aluSrcImmD  (aluSrcImm),
        .aluOpD      (aluOp),
        .memToRegD   (memToReg),
        .memEnD      (memEnD),
        .memWriteD   (memWriteD),
        .branchD     (branch),
        .branchNeD   (branchNe),
        .jumpD       (jump),
        .jumpRegD    (jumpReg),
        .linkD       (link),
        .forwardAE   (forwardAE),
        .forwardBE   (forwardBE),
        .forwardAD   (forwardAD),
        .forwardBD   (forwardBD),
        .stallF      (stallF),
        .stallD      (stallD),
        .flushE      (flushE),
        .rsD         (rsD),
        .rtD         (rtD),
        .rsE         (rsE),
        .rtE         (rtE),
        .writeRegE   (writeRegE),
        .writeRegM   (writeRegM),
        .writeRegW   (writeRegW),
        .regWriteE   (regWriteE),
        .regWriteM   (regWriteM),
        .regWriteW   (regWriteW),
        .memToRegE   (memToRegE),
        .memToRegM   (memToRegM),
        .pc          (pc),
        .memAddr     (memAddr),
        .memWriteData(memWriteData),
        .memEn       (memEn),
        .memWrite    (memWrite),
        .memReadData (memReadData)
    );

endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field of the special opcode
    localparam logic [5:0] functSll  = 6'h00;
    localparam logic [5:0] functSrl  = 6'h02;
    localparam logic [5:0] functJr   = 6'h08;
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functXor  = 6'h26;
    localparam logic [5:0] functSlt  = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdReg = 2'b00, // operand as read in decode
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } forwardSel_t;

    typedef enum logic [1:0] {
        dstRt = 2'b00,
        dstRd = 2'b01,
        dstRa = 2'b10 // $31 for jal
    } regDst_t;

endpackage

/* verilog/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        writeEnable,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    // write in the first half cycle, decode reads the new value in the second
    always_ff @(negedge clk) begin
        if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = (readAddr1 == 5'd0) ? 32'd0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? 32'd0 : regs[readAddr2];

endmodule
